//--- Makefile
# Verilator flow for the UMI memory endpoint

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_umi_endpoint
RTL_TOP   ?= umi_endpoint_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
umi_cmd_pkg.sv
umi_mem_pkg.sv
umi_decode.sv
umi_atomic.sv
umi_unpack.sv
umi_pack.sv
umi_mem_endpoint.sv
umi_endpoint_top.sv
tb_umi_endpoint.sv

//--- tb_umi_endpoint.sv
// Table-driven testbench for the UMI memory endpoint; compile with the file list, top tb_umi_endpoint
module tb_umi_endpoint
   import umi_cmd_pkg::*;
   import umi_mem_pkg::*;
;

   localparam int MAX_ROWS     = 128;
   localparam int RESET_CYCLES = 10;

   logic  clk = 1'b0;
   logic  reset;
   logic  req_valid;
   cmd_t  req_cmd;
   addr_t req_addr;
   data_t req_data;
   logic  resp_valid;
   cmd_t  resp_cmd;
   data_t resp_data;

   // Stimulus table with one row per cycle
   logic    row_valid  [MAX_ROWS];          // 0 marks an idle cycle
   opcode_t row_op     [MAX_ROWS];
   size_t   row_size   [MAX_ROWS];
   len_t    row_len    [MAX_ROWS];          // atype for atomics
   hostid_t row_hostid [MAX_ROWS];
   qos_t    row_qos    [MAX_ROWS];
   prot_t   row_prot   [MAX_ROWS];
   logic [4:0] row_ctl [MAX_ROWS];          // User, ex, eof and eom bits
   addr_t   row_addr   [MAX_ROWS];
   data_t   row_data   [MAX_ROWS];
   int      n_rows = 0;

   data_t ref_mem [MEM_DEPTH];              // Memory model
   cmd_t  exp_cmd_q[$];
   data_t exp_data_q[$];
   int    exp_due_q[$];                     // Cycle the response must show up

   int cycle        = 0;
   int cycle_limit  = 0;
   int cmd_errors   = 0;
   int data_errors  = 0;
   int proto_errors = 0;
   int total_errors;

   umi_endpoint_top u_dut (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_cmd    (req_cmd),
      .req_addr   (req_addr),
      .req_data   (req_data),
      .resp_valid (resp_valid),
      .resp_cmd   (resp_cmd),
      .resp_data  (resp_data)
   );

   always #50 clk = ~clk;                   // Period 100

   task automatic check_cmd(input cmd_t got, input cmd_t exp);
      if (got !== exp) begin
         $display("error at %0t: resp_cmd is %h, expected %h", $time, got, exp);
         cmd_errors++;
      end
   endtask

   task automatic check_data(input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("error at %0t: resp_data is %h, expected %h", $time, got, exp);
         data_errors++;
      end
   endtask

   // Reference ALU straight from the atomic rules
   function automatic data_t atomic_model(input atype_t at, input data_t m, input data_t d);
      case (at)
         AT_ADD:  return m + d;
         AT_AND:  return m & d;
         AT_OR:   return m | d;
         AT_XOR:  return m ^ d;
         AT_MAX:  return ($signed(m) >= $signed(d)) ? m : d;
         AT_MIN:  return ($signed(m) <= $signed(d)) ? m : d;
         AT_MAXU: return (m >= d) ? m : d;
         AT_MINU: return (m <= d) ? m : d;
         AT_SWAP: return d;
         default: return m;
      endcase
   endfunction

   task automatic add_req(input opcode_t op, input size_t sz, input len_t ln,
                          input mem_index_t ix, input data_t d);
      logic [31:0] r;
      logic [31:0] hi;
      logic [31:0] lo;
      r  = $urandom();
      hi = $urandom();
      lo = $urandom();
      row_valid[n_rows]  = 1'b1;
      row_op[n_rows]     = op;
      row_size[n_rows]   = sz;
      row_len[n_rows]    = ln;
      row_hostid[n_rows] = r[4:0];
      row_qos[n_rows]    = r[11:8];            // Must not leak into the response
      row_prot[n_rows]   = r[13:12];
      row_ctl[n_rows]    = r[20:16];           // Ignored on the request side
      row_addr[n_rows]   = {hi, lo};          // Upper bits alias onto the index
      row_addr[n_rows][7:2] = ix;
      row_data[n_rows]   = d;
      n_rows++;
   endtask

   task automatic add_idle();
      row_valid[n_rows] = 1'b0;
      n_rows++;
   endtask

   task automatic build_table();
      data_t word;
      data_t opnd;
      // Reads after reset
      add_req(OP_REQ_READ, SIZE_WORD, '0, 6'd5, $urandom());
      add_req(OP_REQ_READ, SIZE_WORD, '0, 6'd63, '0);
      add_idle();
      // Write and posted write each read back
      add_req(OP_REQ_WRITE, SIZE_WORD, '0, 6'd10, $urandom());
      add_req(OP_REQ_READ, SIZE_WORD, '0, 6'd10, '0);
      add_req(OP_REQ_POSTED, SIZE_WORD, '0, 6'd11, $urandom());   // No response
      add_req(OP_REQ_READ, SIZE_WORD, '0, 6'd11, '0);
      add_idle();
      // All atomics with a negative old word for the compare codes
      for (int a = 0; a <= 8; a++) begin
         word = $urandom();
         opnd = $urandom();
         if (a >= 4 && a <= 7) begin
            word[31] = 1'b1;
            opnd[31] = 1'b0;
         end
         add_req(OP_REQ_WRITE, SIZE_WORD, '0, mem_index_t'(20 + a), word);
         add_req(OP_REQ_ATOMIC, SIZE_WORD, len_t'(a), mem_index_t'(20 + a), opnd);
         add_req(OP_REQ_READ, SIZE_WORD, '0, mem_index_t'(20 + a), '0);
      end
      // Compare codes again with the operand negative instead
      for (int a = 4; a <= 7; a++) begin
         word = $urandom();
         opnd = $urandom();
         word[31] = 1'b0;
         opnd[31] = 1'b1;
         add_req(OP_REQ_WRITE, SIZE_WORD, '0, mem_index_t'(46 + a), word);
         add_req(OP_REQ_ATOMIC, SIZE_WORD, len_t'(a), mem_index_t'(46 + a), opnd);
         add_req(OP_REQ_READ, SIZE_WORD, '0, mem_index_t'(46 + a), '0);
      end
      add_idle();
      // Rejections against a known word
      add_req(OP_REQ_WRITE, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_REQ_READ, 3'd3, '0, 6'd30, '0);                  // 8-byte size
      add_req(OP_REQ_WRITE, 3'd1, '0, 6'd30, $urandom());
      add_req(OP_REQ_READ, SIZE_WORD, 8'd1, 6'd30, '0);           // Two beats
      add_req(OP_REQ_WRITE, SIZE_WORD, 8'd2, 6'd30, $urandom());
      add_req(OP_REQ_ATOMIC, SIZE_WORD, 8'd9, 6'd30, $urandom()); // atype out of range
      add_req(OP_REQ_RDMA, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_REQ_USER0, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_REQ_FUTURE0, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_REQ_POSTED, SIZE_WORD, 8'd1, 6'd30, $urandom()); // Dropped without a response
      add_req(OP_REQ_READ, SIZE_WORD, '0, 6'd30, '0);
      add_idle();
      // Silent opcodes before a read that confirms the word held
      add_req(OP_LINK, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_REQ_ERROR, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_INVALID, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_RESP_READ, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_RESP_WRITE, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_RESP_LINK, SIZE_WORD, '0, 6'd30, $urandom());
      add_req(OP_REQ_READ, SIZE_WORD, '0, 6'd30, '0);
      add_idle();
      // Ten back-to-back requests
      for (int i = 0; i < 5; i++) begin
         add_req(OP_REQ_WRITE, SIZE_WORD, '0, mem_index_t'(40 + i), $urandom());
      end
      for (int i = 0; i < 5; i++) begin
         add_req(OP_REQ_READ, SIZE_WORD, '0, mem_index_t'(40 + i), '0);
      end
   endtask

   // Model update and expected response for one request row
   task automatic predict_response(input int r);
      opcode_t    op;
      mem_index_t ix;
      data_t      old;
      logic       answers;
      logic       good;
      logic       rejected;
      logic       read_type;
      op  = row_op[r];
      ix  = row_addr[r][7:2];
      old = ref_mem[ix];
      answers  = op inside {OP_REQ_READ, OP_REQ_WRITE, OP_REQ_RDMA, OP_REQ_ATOMIC,
                            OP_REQ_USER0, OP_REQ_FUTURE0};
      good     = (row_size[r] == SIZE_WORD) &&
                 ((op == OP_REQ_ATOMIC) ? (row_len[r] <= AT_SWAP) : (row_len[r] == '0));
      rejected = !good || (op inside {OP_REQ_RDMA, OP_REQ_USER0, OP_REQ_FUTURE0});
      if (!rejected && (op == OP_REQ_WRITE || op == OP_REQ_POSTED))
         ref_mem[ix] = row_data[r];
      else if (!rejected && op == OP_REQ_ATOMIC)
         ref_mem[ix] = atomic_model(row_len[r], old, row_data[r]);
      if (answers) begin
         read_type = op inside {OP_REQ_READ, OP_REQ_ATOMIC, OP_REQ_RDMA};
         exp_cmd_q.push_back({row_hostid[r], rejected ? ERR_DEVICE : ERR_OK,
                              3'b001, 2'b00, 4'h0, row_len[r], row_size[r],
                              read_type ? OP_RESP_READ : OP_RESP_WRITE}); // eom only
         exp_data_q.push_back((!rejected && op != OP_REQ_WRITE) ? old : '0);
         exp_due_q.push_back(cycle + 1);      // Latency one
      end
   endtask

   task automatic apply_row(input int r);
      req_valid = row_valid[r];
      req_cmd   = {row_hostid[r], row_ctl[r], row_prot[r], row_qos[r],
                   row_len[r], row_size[r], row_op[r]};
      req_addr  = row_addr[r];
      req_data  = row_data[r];
      if (row_valid[r])
         predict_response(r);
   endtask

   // Cycle count and run limit
   always @(posedge clk) begin
      if (!reset)
         cycle = cycle + 1;
      if (cycle > cycle_limit && !reset) begin
         $display("timeout after %0d cycles, responses still pending: %0d",
                  cycle, exp_cmd_q.size());
         $display("** FAIL **");
         $finish;
      end
   end

   // Response monitor samples at the falling edge where outputs are settled
   always @(negedge clk) begin
      if (!reset) begin
         if (resp_valid) begin
            if (exp_cmd_q.size() == 0 || exp_due_q[0] != cycle) begin
               $display("unexpected response in cycle %0d, no request was due", cycle);
               proto_errors++;
            end else begin
               check_cmd(resp_cmd, exp_cmd_q.pop_front());
               check_data(resp_data, exp_data_q.pop_front());
               void'(exp_due_q.pop_front());
            end
         end else if (exp_cmd_q.size() != 0 && exp_due_q[0] == cycle) begin
            $display("missing response in cycle %0d, the DUT did not answer", cycle);
            proto_errors++;
            void'(exp_cmd_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_due_q.pop_front());
         end
      end
   end

   initial begin
      void'($urandom(32'hbc7fe59d));
      reset     = 1'b1;
      req_valid = 1'b0;
      req_cmd   = '0;
      req_addr  = '0;
      req_data  = '0;
      for (int i = 0; i < MEM_DEPTH; i++) begin
         ref_mem[i] = '0;                     // Matches the cleared memory
      end
      build_table();
      cycle_limit = 2 * n_rows + 50;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      for (int r = 0; r < n_rows; r++) begin
         @(negedge clk);
         apply_row(r);
      end
      @(negedge clk);
      req_valid = 1'b0;
      while (exp_cmd_q.size() != 0) @(negedge clk);
      repeat (3) @(negedge clk);              // Catch late extra responses
      total_errors = cmd_errors + data_errors + proto_errors;
      $display("errors: cmd %0d, data %0d, protocol %0d", cmd_errors, data_errors,
               proto_errors);
      if (total_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- umi_atomic.sv
// Atomic ALU computing the new memory word from the old word and the request operand
module umi_atomic
   import umi_mem_pkg::*;
(
   input  atype_t atype,
   input  data_t  mem_word,
   input  data_t  operand,
   output data_t  result
);

   logic max_s;                              // Old word is signed-greater
   logic max_u;                              // Old word is unsigned-greater

   assign max_s = $signed(mem_word) > $signed(operand);
   assign max_u = mem_word > operand;

   always_comb begin
      case (atype)
         AT_ADD:  result = mem_word + operand;         // Wraps
         AT_AND:  result = mem_word & operand;
         AT_OR:   result = mem_word | operand;
         AT_XOR:  result = mem_word ^ operand;
         AT_MAX:  result = max_s ? mem_word : operand;
         AT_MIN:  result = max_s ? operand : mem_word;
         AT_MAXU: result = max_u ? mem_word : operand;
         AT_MINU: result = max_u ? operand : mem_word;
         AT_SWAP: result = operand;                    // Old word goes back in the response
         default: result = mem_word;                   // Illegal code keeps memory as is
      endcase
   end

endmodule

//--- umi_cmd_pkg.sv
// UMI command word layout, opcodes and field types, imported by every block that handles commands
package umi_cmd_pkg;

   localparam int CMD_W = 32;                // Command word width

   // Field positions within the command word
   localparam int CMD_OPCODE_LSB   = 0;
   localparam int CMD_SIZE_LSB     = 5;
   localparam int CMD_LEN_LSB      = 8;      // Also the atomic type
   localparam int CMD_QOS_LSB      = 16;
   localparam int CMD_PROT_LSB     = 20;
   localparam int CMD_EOM_BIT      = 22;
   localparam int CMD_EOF_BIT      = 23;
   localparam int CMD_EX_BIT       = 24;
   localparam int CMD_USER_LSB     = 25;     // Requests only
   localparam int CMD_ERR_LSB      = 25;     // Same bits, responses only
   localparam int CMD_HOSTID_LSB   = 27;
   localparam int CMD_USER_EXT_LSB = 8;      // Spans len up to user

   typedef logic [CMD_W-1:0] cmd_t;          // Whole command word
   typedef logic [4:0]       opcode_t;       // Bits 4..0
   typedef logic [2:0]       size_t;         // Bits 7..5, log2 of bytes
   typedef logic [7:0]       len_t;          // Bits 15..8, beats minus one
   typedef logic [3:0]       qos_t;          // Bits 19..16
   typedef logic [1:0]       prot_t;         // Bits 21..20
   typedef logic [1:0]       user_t;         // Bits 26..25 in requests
   typedef logic [1:0]       err_t;          // Bits 26..25 in responses
   typedef logic [4:0]       hostid_t;       // Bits 31..27
   typedef logic [18:0]      user_ext_t;     // Bits 26..8

   // Request opcodes, all odd
   localparam opcode_t OP_INVALID      = 5'h00;
   localparam opcode_t OP_REQ_READ     = 5'h01;
   localparam opcode_t OP_REQ_WRITE    = 5'h03;
   localparam opcode_t OP_REQ_POSTED   = 5'h05;
   localparam opcode_t OP_REQ_RDMA     = 5'h07;
   localparam opcode_t OP_REQ_ATOMIC   = 5'h09;
   localparam opcode_t OP_REQ_USER0    = 5'h0B;
   localparam opcode_t OP_REQ_FUTURE0  = 5'h0D;
   localparam opcode_t OP_REQ_ERROR    = 5'h0F;
   localparam opcode_t OP_LINK         = 5'h1F; // Link control, never answered

   // Response opcodes, all even
   localparam opcode_t OP_RESP_READ    = 5'h02;
   localparam opcode_t OP_RESP_WRITE   = 5'h04;
   localparam opcode_t OP_RESP_USER0   = 5'h06;
   localparam opcode_t OP_RESP_USER1   = 5'h08;
   localparam opcode_t OP_RESP_FUTURE0 = 5'h0A;
   localparam opcode_t OP_RESP_FUTURE1 = 5'h0C;
   localparam opcode_t OP_RESP_LINK    = 5'h0E;

   // Response error codes
   localparam err_t ERR_OK     = 2'b00;
   localparam err_t ERR_DEVICE = 2'b10;

   localparam size_t SIZE_WORD = 3'd2;       // 4 bytes per beat

endpackage

//--- umi_decode.sv
// Opcode classifier producing one-hot command class flags, used inside the unpacker
module umi_decode
   import umi_cmd_pkg::*;
(
   input  cmd_t command,
   output logic cmd_invalid,
   output logic cmd_request,
   output logic cmd_response,
   output logic cmd_read,
   output logic cmd_write,
   output logic cmd_write_posted,
   output logic cmd_rdma,
   output logic cmd_atomic,
   output logic cmd_user0,
   output logic cmd_future0,
   output logic cmd_error,
   output logic cmd_link,
   output logic cmd_read_resp,
   output logic cmd_write_resp,
   output logic cmd_link_resp
);

   opcode_t opcode;

   assign opcode = command[CMD_OPCODE_LSB +: $bits(opcode_t)];

   // Special codes
   assign cmd_invalid = (opcode == OP_INVALID);    // All zero
   assign cmd_error   = (opcode == OP_REQ_ERROR);  // Odd but not a request
   assign cmd_link    = (opcode == OP_LINK);       // Odd but not a request

   // Broad classes
   assign cmd_request  = opcode[0] & ~cmd_error & ~cmd_link; // Odd opcodes
   assign cmd_response = ~opcode[0] & ~cmd_invalid;          // Even, non-zero

   // Individual requests
   assign cmd_read         = (opcode == OP_REQ_READ);
   assign cmd_write        = (opcode == OP_REQ_WRITE);  // Acked write
   assign cmd_write_posted = (opcode == OP_REQ_POSTED); // No ack
   assign cmd_rdma         = (opcode == OP_REQ_RDMA);
   assign cmd_atomic       = (opcode == OP_REQ_ATOMIC);
   assign cmd_user0        = (opcode == OP_REQ_USER0);
   assign cmd_future0      = (opcode == OP_REQ_FUTURE0);

   // Individual responses
   assign cmd_read_resp  = (opcode == OP_RESP_READ);  // Also atomic return
   assign cmd_write_resp = (opcode == OP_RESP_WRITE); // Write ack
   assign cmd_link_resp  = (opcode == OP_RESP_LINK);

endmodule

//--- umi_endpoint_top.sv
// Top level of the UMI memory endpoint, wiring unpacker, endpoint and packer to the request ports
module umi_endpoint_top
   import umi_cmd_pkg::*;
   import umi_mem_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  req_valid,                  // One-cycle strobe
   input  cmd_t  req_cmd,
   input  addr_t req_addr,
   input  data_t req_data,
   output logic  resp_valid,                 // One cycle after the request
   output cmd_t  resp_cmd,
   output data_t resp_data
);

   opcode_t cmd_opcode;
   size_t   cmd_size;
   len_t    cmd_len;
   atype_t  cmd_atype;
   hostid_t cmd_hostid;
   logic    cmd_request;
   logic    cmd_read;
   logic    cmd_write;
   logic    cmd_write_posted;
   logic    cmd_atomic;
   opcode_t rsp_opcode;
   size_t   rsp_size;
   len_t    rsp_len;
   hostid_t rsp_hostid;
   err_t    rsp_err;

   umi_unpack u_unpack (
      .packet_cmd        (req_cmd),
      .cmd_opcode        (cmd_opcode),
      .cmd_size          (cmd_size),
      .cmd_len           (cmd_len),
      .cmd_atype         (cmd_atype),
      .cmd_qos           (),
      .cmd_prot          (),
      .cmd_eom           (),
      .cmd_eof           (),
      .cmd_ex            (),
      .cmd_user          (),
      .cmd_user_extended (),
      .cmd_err           (),
      .cmd_hostid        (cmd_hostid),
      .cmd_request       (cmd_request),
      .cmd_read          (cmd_read),
      .cmd_write         (cmd_write),
      .cmd_write_posted  (cmd_write_posted),
      .cmd_atomic        (cmd_atomic)
   );

   umi_mem_endpoint u_endpoint (
      .clk              (clk),
      .reset            (reset),
      .req_valid        (req_valid),
      .cmd_request      (cmd_request),
      .cmd_read         (cmd_read),
      .cmd_write        (cmd_write),
      .cmd_write_posted (cmd_write_posted),
      .cmd_atomic       (cmd_atomic),
      .cmd_opcode       (cmd_opcode),
      .cmd_size         (cmd_size),
      .cmd_len          (cmd_len),
      .cmd_atype        (cmd_atype),
      .cmd_hostid       (cmd_hostid),
      .req_addr         (req_addr),
      .req_data         (req_data),
      .rsp_valid        (resp_valid),
      .rsp_opcode       (rsp_opcode),
      .rsp_size         (rsp_size),
      .rsp_len          (rsp_len),
      .rsp_hostid       (rsp_hostid),
      .rsp_err          (rsp_err),
      .rsp_data         (resp_data)
   );

   umi_pack u_pack (
      .opcode     (rsp_opcode),
      .size       (rsp_size),
      .len        (rsp_len),
      .hostid     (rsp_hostid),
      .err        (rsp_err),
      .packet_cmd (resp_cmd)
   );

endmodule

//--- umi_mem_endpoint.sv
// Word memory endpoint executing single-beat UMI requests and registering the response fields
module umi_mem_endpoint
   import umi_cmd_pkg::*;
   import umi_mem_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    req_valid,
   input  logic    cmd_request,
   input  logic    cmd_read,
   input  logic    cmd_write,
   input  logic    cmd_write_posted,
   input  logic    cmd_atomic,
   input  opcode_t cmd_opcode,
   input  size_t   cmd_size,
   input  len_t    cmd_len,
   input  atype_t  cmd_atype,
   input  hostid_t cmd_hostid,
   input  addr_t   req_addr,
   input  data_t   req_data,
   output logic    rsp_valid,
   output opcode_t rsp_opcode,
   output size_t   rsp_size,
   output len_t    rsp_len,
   output hostid_t rsp_hostid,
   output err_t    rsp_err,
   output data_t   rsp_data
);

   // Per-request classification, decided in the same cycle
   typedef enum logic [2:0] {
      REQ_READ,
      REQ_WRITE,
      REQ_POSTED,
      REQ_ATOMIC,
      REQ_REJECT
   } req_kind_t;

   data_t      mem [MEM_DEPTH];              // Word storage
   mem_index_t idx;
   data_t      old_word;                     // Current word at idx
   data_t      atomic_result;
   data_t      wdata;
   logic       supported;
   logic       mem_we;
   logic       rsp_fire;
   logic       read_class;                   // Answers with a read response
   req_kind_t  kind;

   assign idx      = req_addr[IDX_LSB +: $bits(mem_index_t)]; // Upper bits alias
   assign old_word = mem[idx];

   // Atomics reuse len as atype, so only the code range is checked there
   assign supported = (cmd_size == SIZE_WORD) &&
                      (cmd_atomic ? (cmd_atype <= AT_SWAP) : (cmd_len == '0));

   always_comb begin
      kind = REQ_REJECT;                     // RDMA, user0, future0, unsupported
      if (supported) begin
         if (cmd_read)
            kind = REQ_READ;
         else if (cmd_write)
            kind = REQ_WRITE;
         else if (cmd_write_posted)
            kind = REQ_POSTED;
         else if (cmd_atomic)
            kind = REQ_ATOMIC;
      end
   end

   umi_atomic u_atomic (
      .atype    (cmd_atype),
      .mem_word (old_word),
      .operand  (req_data),
      .result   (atomic_result)
   );

   assign wdata  = (kind == REQ_ATOMIC) ? atomic_result : req_data;
   assign mem_we = req_valid &&
                   (kind == REQ_WRITE || kind == REQ_POSTED || kind == REQ_ATOMIC);

   // Posted writes never answer, even when dropped
   assign rsp_fire   = req_valid & cmd_request & ~cmd_write_posted;
   assign read_class = cmd_read | cmd_atomic | (cmd_opcode == OP_REQ_RDMA);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] <= '0;                    // Reads after reset see zero
         end
      end else if (mem_we) begin
         mem[idx] <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= rsp_fire;              // One pulse per answered request
   end

   // Response payload, only loaded when a response goes out
   always_ff @(posedge clk) begin
      if (rsp_fire) begin
         rsp_opcode <= read_class ? OP_RESP_READ : OP_RESP_WRITE;
         rsp_size   <= cmd_size;
         rsp_len    <= cmd_len;
         rsp_hostid <= cmd_hostid;
         rsp_err    <= (kind == REQ_REJECT) ? ERR_DEVICE : ERR_OK;
         rsp_data   <= (kind == REQ_READ || kind == REQ_ATOMIC) ? old_word : '0; // Old value
      end
   end

endmodule

//--- umi_mem_pkg.sv
// Memory geometry, address and data types and atomic codes, imported by the memory endpoint side
package umi_mem_pkg;

   localparam int MEM_DEPTH = 64;            // Words in the endpoint memory
   localparam int ADDR_W    = 64;            // UMI address width
   localparam int DATA_W    = 32;            // One word per beat
   localparam int IDX_W     = $clog2(MEM_DEPTH);
   localparam int IDX_LSB   = 2;             // Byte address to word index
   localparam int ATYPE_W   = 8;

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [IDX_W-1:0]   mem_index_t;  // Address bits 7..2
   typedef logic [ATYPE_W-1:0] atype_t;      // Carried in the len field

   // Atomic operation codes
   localparam atype_t AT_ADD  = 8'd0;
   localparam atype_t AT_AND  = 8'd1;
   localparam atype_t AT_OR   = 8'd2;
   localparam atype_t AT_XOR  = 8'd3;
   localparam atype_t AT_MAX  = 8'd4;        // Signed
   localparam atype_t AT_MIN  = 8'd5;        // Signed
   localparam atype_t AT_MAXU = 8'd6;
   localparam atype_t AT_MINU = 8'd7;
   localparam atype_t AT_SWAP = 8'd8;        // Highest legal code

endpackage

//--- umi_pack.sv
// Response command packer assembling a UMI command word from the endpoint's response fields
module umi_pack
   import umi_cmd_pkg::*;
(
   input  opcode_t opcode,
   input  size_t   size,
   input  len_t    len,
   input  hostid_t hostid,
   input  err_t    err,
   output cmd_t    packet_cmd
);

   // qos, prot, eof and ex stay zero in responses
   always_comb begin
      packet_cmd = '0;
      packet_cmd[CMD_OPCODE_LSB +: $bits(opcode_t)] = opcode;
      packet_cmd[CMD_SIZE_LSB +: $bits(size_t)]     = size;   // Echo of request
      packet_cmd[CMD_LEN_LSB +: $bits(len_t)]       = len;    // Echo, atype for atomics
      packet_cmd[CMD_EOM_BIT]                       = 1'b1;   // Single beat ends message
      packet_cmd[CMD_ERR_LSB +: $bits(err_t)]       = err;    // Shares user bits
      packet_cmd[CMD_HOSTID_LSB +: $bits(hostid_t)] = hostid; // Route back to requester
   end

endmodule

//--- umi_unpack.sv
// Command word unpacker splitting a UMI command into named fields plus request class flags
module umi_unpack
   import umi_cmd_pkg::*;
   import umi_mem_pkg::*;
(
   input  cmd_t      packet_cmd,
   output opcode_t   cmd_opcode,
   output size_t     cmd_size,
   output len_t      cmd_len,
   output atype_t    cmd_atype,
   output qos_t      cmd_qos,
   output prot_t     cmd_prot,
   output logic      cmd_eom,
   output logic      cmd_eof,
   output logic      cmd_ex,
   output user_t     cmd_user,
   output user_ext_t cmd_user_extended,
   output err_t      cmd_err,
   output hostid_t   cmd_hostid,
   output logic      cmd_request,
   output logic      cmd_read,
   output logic      cmd_write,
   output logic      cmd_write_posted,
   output logic      cmd_atomic
);

   logic cmd_response;                       // Qualifies the err field

   umi_decode u_decode (
      .command          (packet_cmd),
      .cmd_invalid      (),
      .cmd_request      (cmd_request),
      .cmd_response     (cmd_response),
      .cmd_read         (cmd_read),
      .cmd_write        (cmd_write),
      .cmd_write_posted (cmd_write_posted),
      .cmd_rdma         (),
      .cmd_atomic       (cmd_atomic),
      .cmd_user0        (),
      .cmd_future0      (),
      .cmd_error        (),
      .cmd_link         (),
      .cmd_read_resp    (),
      .cmd_write_resp   (),
      .cmd_link_resp    ()
   );

   assign cmd_opcode = packet_cmd[CMD_OPCODE_LSB +: $bits(opcode_t)];
   assign cmd_size   = packet_cmd[CMD_SIZE_LSB +: $bits(size_t)];  // Meaningless for link
   assign cmd_len    = packet_cmd[CMD_LEN_LSB +: $bits(len_t)];
   assign cmd_atype  = packet_cmd[CMD_LEN_LSB +: $bits(atype_t)];  // Same bits as len
   assign cmd_qos    = packet_cmd[CMD_QOS_LSB +: $bits(qos_t)];
   assign cmd_prot   = packet_cmd[CMD_PROT_LSB +: $bits(prot_t)];
   assign cmd_eom    = packet_cmd[CMD_EOM_BIT];
   assign cmd_eof    = packet_cmd[CMD_EOF_BIT];                    // Requests only
   assign cmd_ex     = packet_cmd[CMD_EX_BIT];                     // Requests only
   assign cmd_user   = packet_cmd[CMD_USER_LSB +: $bits(user_t)];
   assign cmd_hostid = packet_cmd[CMD_HOSTID_LSB +: $bits(hostid_t)];

   assign cmd_user_extended = packet_cmd[CMD_USER_EXT_LSB +: $bits(user_ext_t)];

   // User bits only mean error on the response side
   assign cmd_err = cmd_response ? packet_cmd[CMD_ERR_LSB +: $bits(err_t)] : '0;

endmodule
